// ==== src/frontEnd_params.svh ====
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// Warps tracked as one-hot masks
`define WARPS 8

// PC and instruction width
`define XLEN 32

// Return addresses held per warp
`define STACK_DEPTH 4

`endif

// ==== src/simtPkg.sv ====
`include "frontEnd_params.svh"

package simtPkg;

	typedef logic [`XLEN-1:0] word_t;                // PC or instruction word
	typedef logic [`WARPS-1:0] warpMask_t;           // One bit per warp
	typedef logic [4:0] regIdx_t;
	typedef logic [15:0] imm_t;
	typedef logic [5:0] opcode_t;
	typedef logic [3:0] aluOp_t;
	typedef logic [$clog2(`WARPS):0] warpCount_t;    // Holds 0 up to WARPS

	// ALU operation codes
	localparam aluOp_t ALU_ADD = 4'd0;
	localparam aluOp_t ALU_SUB = 4'd1;
	localparam aluOp_t ALU_MUL = 4'd2;
	localparam aluOp_t ALU_AND = 4'd3;
	localparam aluOp_t ALU_OR  = 4'd4;
	localparam aluOp_t ALU_XOR = 4'd5;
	localparam aluOp_t ALU_SHR = 4'd6;
	localparam aluOp_t ALU_SHL = 4'd7;
	localparam aluOp_t ALU_INV = 4'd15;              // Unknown function code

	typedef enum logic [1:0] {
		sIdle,
		sFetch,
		sDone
	} schedState_t;

endpackage

// ==== src/instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode (
	input  simtPkg::word_t   instr,
	output simtPkg::aluOp_t  aluOp,
	output simtPkg::regIdx_t dst,
	output simtPkg::imm_t    imm,
	output simtPkg::word_t   target,
	output logic             regWrite,
	output logic             memRead,
	output logic             memWrite,
	output logic             shared,
	output logic             dotS,
	output logic             immValid,
	output logic             src1Valid,
	output logic             src2Valid,
	output logic             beq,
	output logic             blt,
	output logic             jmp,
	output logic             call,
	output logic             ret,
	output logic             exit
);
	import simtPkg::*;

	opcode_t opcode;
	regIdx_t rt;
	regIdx_t rd;
	logic [5:0] funct;
	logic [12:0] ctrl;

	assign opcode = instr[31:26];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign funct = instr[5:0];

	// regWrite memRead memWrite shared immValid src1 src2 | beq blt jmp call ret exit
	assign {regWrite, memRead, memWrite, shared, immValid, src1Valid, src2Valid,
		beq, blt, jmp, call, ret, exit} = ctrl;

	// Bit 4 of the opcode marks the .S variant
	always_comb begin
		case (opcode)
			6'b000000, 6'b010000:
				ctrl = 13'b1000011_000000;   // ALU register
			6'b001000, 6'b011000, 6'b001100, 6'b011100,
			6'b001101, 6'b011101, 6'b001110, 6'b011110:
				ctrl = 13'b1000110_000000;   // ADDI ANDI ORI XORI
			6'b100011, 6'b110011:
				ctrl = 13'b1100110_000000;   // LD
			6'b100111, 6'b110111:
				ctrl = 13'b1101110_000000;   // LDS
			6'b101011, 6'b111011:
				ctrl = 13'b0010111_000000;   // SW
			6'b101111, 6'b111111:
				ctrl = 13'b0011111_000000;   // SWS
			6'b000100, 6'b010100:
				ctrl = 13'b0000011_100000;   // BEQ
			6'b000111, 6'b010111:
				ctrl = 13'b0000011_010000;   // BLT
			6'b000010, 6'b010010:
				ctrl = 13'b0000000_001000;   // J
			6'b000011:
				ctrl = 13'b0000000_000100;   // CALL
			6'b000110:
				ctrl = 13'b0000000_000010;   // RET
			6'b100001:
				ctrl = 13'b0000000_000001;   // EXIT
			default:
				ctrl = '0;
		endcase
	end

	always_comb begin
		if (immValid) begin
			case (opcode[3:0])
				4'b1000: aluOp = ALU_ADD;   // ADDI
				4'b1100: aluOp = ALU_AND;   // ANDI
				4'b1101: aluOp = ALU_OR;    // ORI
				4'b1110: aluOp = ALU_XOR;   // XORI
				default: aluOp = ALU_INV;
			endcase
		end else begin
			case (funct)
				6'b100000: aluOp = ALU_ADD;
				6'b100010: aluOp = ALU_SUB;
				6'b011000: aluOp = ALU_MUL;
				6'b100100: aluOp = ALU_AND;
				6'b100101: aluOp = ALU_OR;
				6'b100110: aluOp = ALU_XOR;
				6'b000010: aluOp = ALU_SHR;
				6'b000000: aluOp = ALU_SHL;
				default:   aluOp = ALU_INV;
			endcase
		end
	end

	assign dotS = opcode[4];
	assign dst = (memRead || immValid) ? rt : rd;   // Loads and immediates write rt
	assign imm = instr[15:0];
	assign target = {4'b0000, instr[25:0], 2'b00};   // Word index to byte address

endmodule

// ==== src/warpScheduler.sv ====
`timescale 1ns/1ps
`include "frontEnd_params.svh"

module warpScheduler (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  simtPkg::warpMask_t launchMask,
	input  simtPkg::warpMask_t slotFull,
	input  logic               exitFetch,
	input  logic               allRetired,
	output logic               fetchValid,
	output simtPkg::warpMask_t fetchWarp,
	output logic               busy
);
	import simtPkg::*;

	localparam int IDXW = $clog2(`WARPS);

	schedState_t state;
	warpMask_t active;
	warpMask_t eligible;
	logic [IDXW-1:0] lastWarp;
	logic [IDXW-1:0] pickIdx;

	assign eligible = (state == sFetch) ? (active & ~slotFull) : '0;
	assign fetchValid = |eligible;
	assign busy = (state == sFetch);

	// Walk from farthest to nearest so the warp right after lastWarp wins
	always_comb begin
		int idx;
		pickIdx = lastWarp;
		fetchWarp = '0;
		for (int i = `WARPS; i > 0; i--) begin
			idx = (int'(lastWarp) + i) % `WARPS;
			if (eligible[idx]) begin
				pickIdx = IDXW'(idx);
				fetchWarp = warpMask_t'(1) << idx;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sIdle;
			active <= '0;
			lastWarp <= IDXW'(`WARPS - 1);
		end else begin
			case (state)
				sIdle, sDone: begin
					if (start) begin
						state <= sFetch;
						active <= launchMask;
						lastWarp <= IDXW'(`WARPS - 1);   // Warp 0 goes first
					end
				end
				sFetch: begin
					if (fetchValid) begin
						lastWarp <= pickIdx;
						if (exitFetch)
							active <= active & ~fetchWarp;
					end
					if (allRetired)
						state <= sDone;
				end
				default: state <= sIdle;
			endcase
		end
	end

endmodule

// ==== src/pcTable.sv ====
`timescale 1ns/1ps
`include "frontEnd_params.svh"

module pcTable (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  simtPkg::word_t     startPc,
	input  simtPkg::warpMask_t launchMask,
	input  logic               fetchValid,
	input  simtPkg::warpMask_t fetchWarp,
	input  logic               jump,
	input  simtPkg::word_t     target,
	input  logic               ret,
	input  simtPkg::word_t     retPc,
	output simtPkg::word_t     fetchAddr,
	output simtPkg::word_t     nextPc
);
	import simtPkg::*;

	word_t pc [`WARPS];

	always_comb begin
		fetchAddr = '0;
		for (int w = 0; w < `WARPS; w++) begin
			if (fetchWarp[w])
				fetchAddr = pc[w];
		end
	end

	assign nextPc = fetchAddr + word_t'(4);   // Also the CALL return address

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `WARPS; w++)
				pc[w] <= '0;
		end else begin
			for (int w = 0; w < `WARPS; w++) begin
				if (start && launchMask[w])
					pc[w] <= startPc;
				else if (fetchValid && fetchWarp[w])
					pc[w] <= jump ? target : (ret ? retPc : nextPc);
			end
		end
	end

endmodule

// ==== src/callStack.sv ====
`timescale 1ns/1ps
`include "frontEnd_params.svh"

module callStack (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  logic               fetchValid,
	input  simtPkg::warpMask_t fetchWarp,
	input  logic               call,
	input  logic               ret,
	input  simtPkg::word_t     pushPc,
	output simtPkg::word_t     popPc,
	output simtPkg::warpMask_t empty
);
	import simtPkg::*;

	localparam int IDXW = $clog2(`WARPS);
	localparam int SPW = $clog2(`STACK_DEPTH) + 1;

	word_t stack [`WARPS][`STACK_DEPTH];
	logic [SPW-1:0] sp [`WARPS];   // Entries in use per warp
	logic [SPW-1:0] topPtr;
	logic [IDXW-1:0] fetchIdx;
	logic doPush;
	logic doPop;

	always_comb begin
		fetchIdx = '0;
		for (int w = 0; w < `WARPS; w++) begin
			if (fetchWarp[w])
				fetchIdx = IDXW'(w);
			empty[w] = (sp[w] == '0);
		end
	end

	assign topPtr = sp[fetchIdx] - 1'b1;
	assign popPc = stack[fetchIdx][topPtr[SPW-2:0]];
	assign doPush = fetchValid && call && (sp[fetchIdx] != SPW'(`STACK_DEPTH));   // Drop on overflow
	assign doPop = fetchValid && ret && !empty[fetchIdx];

	always_ff @(posedge clk) begin
		if (rst || start) begin
			for (int w = 0; w < `WARPS; w++)
				sp[w] <= '0;
		end else if (doPush) begin
			sp[fetchIdx] <= sp[fetchIdx] + 1'b1;
		end else if (doPop) begin
			sp[fetchIdx] <= topPtr;
		end
	end

	always_ff @(posedge clk) begin
		if (doPush)
			stack[fetchIdx][sp[fetchIdx][SPW-2:0]] <= pushPc;
	end

endmodule

// ==== src/instrBuffer.sv ====
`timescale 1ns/1ps
`include "frontEnd_params.svh"

module instrBuffer (
	input  logic               clk,
	input  logic               rst,
	input  logic               fetchValid,
	input  simtPkg::warpMask_t fetchWarp,
	input  simtPkg::word_t     fetchAddr,
	input  simtPkg::word_t     instr,
	input  simtPkg::aluOp_t    aluOp,
	input  simtPkg::regIdx_t   dst,
	input  logic               regWrite,
	input  logic               memRead,
	input  logic               memWrite,
	input  logic               shared,
	input  logic               immValid,
	input  logic               src1Valid,
	input  logic               src2Valid,
	input  logic               branch,
	input  logic               issueAck,
	output simtPkg::warpMask_t slotFull,
	output logic               issueValid,
	output simtPkg::warpMask_t issueWarp,
	output simtPkg::word_t     issuePc,
	output simtPkg::word_t     issueInstr,
	output simtPkg::aluOp_t    issueAluOp,
	output simtPkg::regIdx_t   issueDst,
	output logic               issueRegWrite,
	output logic               issueMemRead,
	output logic               issueMemWrite,
	output logic               issueShared,
	output logic               issueImmValid,
	output logic               issueSrc1Valid,
	output logic               issueSrc2Valid,
	output logic               issueBranch
);
	import simtPkg::*;

	localparam int IDXW = $clog2(`WARPS);

	word_t pcSlot [`WARPS];
	word_t instrSlot [`WARPS];
	aluOp_t opSlot [`WARPS];
	regIdx_t dstSlot [`WARPS];
	logic [7:0] flagSlot [`WARPS];
	logic [IDXW-1:0] issueIdx;

	// Lowest full slot wins
	always_comb begin
		issueIdx = '0;
		for (int w = `WARPS - 1; w >= 0; w--) begin
			if (slotFull[w])
				issueIdx = IDXW'(w);
		end
	end

	assign issueValid = |slotFull;
	assign issueWarp = issueValid ? (warpMask_t'(1) << issueIdx) : '0;
	assign issuePc = pcSlot[issueIdx];
	assign issueInstr = instrSlot[issueIdx];
	assign issueAluOp = opSlot[issueIdx];
	assign issueDst = dstSlot[issueIdx];
	assign {issueRegWrite, issueMemRead, issueMemWrite, issueShared,
		issueImmValid, issueSrc1Valid, issueSrc2Valid, issueBranch} = flagSlot[issueIdx];

	always_ff @(posedge clk) begin
		if (rst)
			slotFull <= '0;
		else
			slotFull <= (slotFull & ~((issueAck && issueValid) ? issueWarp : '0))
				| (fetchValid ? fetchWarp : '0);
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < `WARPS; w++) begin
			if (fetchValid && fetchWarp[w]) begin
				pcSlot[w] <= fetchAddr;
				instrSlot[w] <= instr;
				opSlot[w] <= aluOp;
				dstSlot[w] <= dst;
				flagSlot[w] <= {regWrite, memRead, memWrite, shared,
					immValid, src1Valid, src2Valid, branch};
			end
		end
	end

endmodule

// ==== src/retireCounter.sv ====
`timescale 1ns/1ps
`include "frontEnd_params.svh"

module retireCounter (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  simtPkg::warpMask_t  launchMask,
	input  logic                exitFetch,
	output simtPkg::warpCount_t retiredWarps,
	output logic                allRetired
);
	import simtPkg::*;

	warpCount_t launched;
	warpCount_t launchCount;

	always_comb begin
		launchCount = '0;
		for (int i = 0; i < `WARPS; i++)
			launchCount = launchCount + warpCount_t'(launchMask[i]);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			launched <= '0;
			retiredWarps <= '0;
		end else if (start) begin
			launched <= launchCount;
			retiredWarps <= '0;
		end else if (exitFetch) begin
			retiredWarps <= retiredWarps + 1'b1;
		end
	end

	assign allRetired = (retiredWarps == launched) && (launched != '0);   // Empty launch never completes

endmodule

// ==== src/simtFrontEnd.sv ====
`timescale 1ns/1ps
`include "frontEnd_params.svh"

module simtFrontEnd (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  simtPkg::warpMask_t  launchMask,
	input  simtPkg::word_t      startPc,
	input  simtPkg::word_t      fetchInstr,
	input  logic                issueAck,
	output logic                fetchValid,
	output simtPkg::warpMask_t  fetchWarp,
	output simtPkg::word_t      fetchAddr,
	output logic                issueValid,
	output simtPkg::warpMask_t  issueWarp,
	output simtPkg::word_t      issuePc,
	output simtPkg::word_t      issueInstr,
	output simtPkg::aluOp_t     issueAluOp,
	output simtPkg::regIdx_t    issueDst,
	output logic                issueRegWrite,
	output logic                issueMemRead,
	output logic                issueMemWrite,
	output logic                issueShared,
	output logic                issueImmValid,
	output logic                issueSrc1Valid,
	output logic                issueSrc2Valid,
	output logic                issueBranch,
	output logic                busy,
	output logic                kernelDone,
	output simtPkg::warpCount_t retiredWarps
);
	import simtPkg::*;

	warpMask_t slotFull;
	warpMask_t stackEmpty;
	word_t target;
	word_t nextPc;
	word_t popPc;
	aluOp_t aluOp;
	regIdx_t dst;
	logic regWrite, memRead, memWrite, shared, immValid, src1Valid, src2Valid;
	logic beq, blt, jmp, call, ret, exit;
	logic exitFetch, branch, jump, allRetired;

	assign exitFetch = fetchValid && exit;
	assign branch = beq || blt;   // Flagged only, execution falls through
	assign jump = jmp || call;
	assign kernelDone = allRetired;

	warpScheduler i_warpScheduler (
		.clk(clk), .rst(rst), .start(start), .launchMask(launchMask),
		.slotFull(slotFull), .exitFetch(exitFetch), .allRetired(allRetired),
		.fetchValid(fetchValid), .fetchWarp(fetchWarp), .busy(busy)
	);

	instrDecode i_instrDecode (
		.instr(fetchInstr), .aluOp(aluOp), .dst(dst), .imm(), .target(target),
		.regWrite(regWrite), .memRead(memRead), .memWrite(memWrite), .shared(shared),
		.dotS(), .immValid(immValid), .src1Valid(src1Valid), .src2Valid(src2Valid),
		.beq(beq), .blt(blt), .jmp(jmp), .call(call), .ret(ret), .exit(exit)
	);

	pcTable i_pcTable (
		.clk(clk), .rst(rst), .start(start), .startPc(startPc), .launchMask(launchMask),
		.fetchValid(fetchValid), .fetchWarp(fetchWarp), .jump(jump), .target(target),
		.ret(ret), .retPc(popPc), .fetchAddr(fetchAddr), .nextPc(nextPc)
	);

	callStack i_callStack (
		.clk(clk), .rst(rst), .start(start), .fetchValid(fetchValid),
		.fetchWarp(fetchWarp), .call(call), .ret(ret), .pushPc(nextPc),
		.popPc(popPc), .empty(stackEmpty)
	);

	instrBuffer i_instrBuffer (
		.clk(clk), .rst(rst), .fetchValid(fetchValid), .fetchWarp(fetchWarp),
		.fetchAddr(fetchAddr), .instr(fetchInstr), .aluOp(aluOp), .dst(dst),
		.regWrite(regWrite), .memRead(memRead), .memWrite(memWrite), .shared(shared),
		.immValid(immValid), .src1Valid(src1Valid), .src2Valid(src2Valid),
		.branch(branch), .issueAck(issueAck), .slotFull(slotFull),
		.issueValid(issueValid), .issueWarp(issueWarp), .issuePc(issuePc),
		.issueInstr(issueInstr), .issueAluOp(issueAluOp), .issueDst(issueDst),
		.issueRegWrite(issueRegWrite), .issueMemRead(issueMemRead),
		.issueMemWrite(issueMemWrite), .issueShared(issueShared),
		.issueImmValid(issueImmValid), .issueSrc1Valid(issueSrc1Valid),
		.issueSrc2Valid(issueSrc2Valid), .issueBranch(issueBranch)
	);

	retireCounter i_retireCounter (
		.clk(clk), .rst(rst), .start(start), .launchMask(launchMask),
		.exitFetch(exitFetch), .retiredWarps(retiredWarps), .allRetired(allRetired)
	);

endmodule

// ==== bench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;   // 4 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== bench/simtFrontEnd_checker.sv ====
`timescale 1ns/1ps

module simtFrontEnd_checker (
	input logic               clk,
	input logic               rst,
	input logic               fetchValid,
	input logic               ret,
	input simtPkg::warpMask_t fetchWarp,
	input simtPkg::warpMask_t slotFull,
	input simtPkg::warpMask_t stackEmpty
);
	int failCount = 0;   // Assertion failures so far

	oneHotFetch: assert property (@(posedge clk) disable iff (rst)
		fetchValid |-> $onehot(fetchWarp))
		else begin
			failCount++;
			$error("fetchWarp is not one-hot during a fetch");
		end

	// Scheduler must skip warps whose buffer slot is taken
	fetchFreeSlot: assert property (@(posedge clk) disable iff (rst)
		fetchValid |-> ((fetchWarp & slotFull) == '0))
		else begin
			failCount++;
			$error("fetch selected a warp with a full slot");
		end

	retNotEmpty: assert property (@(posedge clk) disable iff (rst)
		(fetchValid && ret) |-> ((fetchWarp & stackEmpty) == '0))
		else begin
			failCount++;
			$error("RET fetched with an empty return stack");
		end

endmodule

bind simtFrontEnd simtFrontEnd_checker i_checker (
	.clk(clk),
	.rst(rst),
	.fetchValid(fetchValid),
	.ret(ret),
	.fetchWarp(fetchWarp),
	.slotFull(slotFull),
	.stackEmpty(stackEmpty)
);

// ==== bench/simtFrontEnd_tb.sv ====
`timescale 1ns/1ps
`include "frontEnd_params.svh"

module simtFrontEnd_tb;
	import simtPkg::*;

	localparam int K_PLAIN = 0;
	localparam int K_JUMP = 1;
	localparam int K_CALL = 2;
	localparam int K_RET = 3;
	localparam int K_EXIT = 4;

	logic clk, rst, start, issueAck;
	warpMask_t launchMask;
	word_t startPc, fetchInstr;
	logic fetchValid, issueValid, busy, kernelDone;
	warpMask_t fetchWarp, issueWarp;
	word_t fetchAddr, issuePc, issueInstr;
	aluOp_t issueAluOp;
	regIdx_t issueDst;
	logic issueRegWrite, issueMemRead, issueMemWrite, issueShared;
	logic issueImmValid, issueSrc1Valid, issueSrc2Valid, issueBranch;
	warpCount_t retiredWarps;

	word_t imem [256];   // Instruction memory model, word indexed
	int kind [256];
	int jumpTo [256];    // Byte address a J or CALL goes to
	aluOp_t expOp [256];
	regIdx_t expDst [256];
	logic [7:0] expFlags [256];
	bit chkOp [256];
	bit chkDst [256];
	word_t expTrace [`WARPS][$];   // Expected PC sequence per warp
	int fIdx [`WARPS];
	int iIdx [`WARPS];
	logic [31:0] lfsr = 32'ha0aa;
	int errors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int progLen = 0;
	int cycles = 0;

	clockGen i_clockGen (.clk(clk), .rst(rst));

	simtFrontEnd i_simtFrontEnd (
		.clk(clk), .rst(rst), .start(start), .launchMask(launchMask), .startPc(startPc),
		.fetchInstr(fetchInstr), .issueAck(issueAck), .fetchValid(fetchValid),
		.fetchWarp(fetchWarp), .fetchAddr(fetchAddr), .issueValid(issueValid),
		.issueWarp(issueWarp), .issuePc(issuePc), .issueInstr(issueInstr),
		.issueAluOp(issueAluOp), .issueDst(issueDst), .issueRegWrite(issueRegWrite),
		.issueMemRead(issueMemRead), .issueMemWrite(issueMemWrite),
		.issueShared(issueShared), .issueImmValid(issueImmValid),
		.issueSrc1Valid(issueSrc1Valid), .issueSrc2Valid(issueSrc2Valid),
		.issueBranch(issueBranch), .busy(busy), .kernelDone(kernelDone),
		.retiredWarps(retiredWarps)
	);

	assign fetchInstr = imem[fetchAddr[9:2]];   // Same-cycle fetch answer

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > 2 * progLen * `WARPS + 200) begin
			$display("Timeout: the run did not finish within %0d cycles", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];   // Taps 32 22 2 1
		return {s[30:0], fb};
	endfunction

	function automatic int rrPick(input warpMask_t elig, input int last);
		int w;
		for (int i = 1; i <= `WARPS; i++) begin
			w = (last + i) % `WARPS;
			if (elig[w])
				return w;
		end
		return -1;
	endfunction

	function automatic int lowestSet(input warpMask_t m);
		for (int i = 0; i < `WARPS; i++) begin
			if (m[i])
				return i;
		end
		return -1;
	endfunction

	task automatic checkHex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic clearProgram();
		for (int i = 0; i < 256; i++) begin
			imem[i] = {6'b100001, 26'(i)};   // EXIT tagged with its index
			kind[i] = K_EXIT;
			jumpTo[i] = 0;
			expOp[i] = '0;
			expDst[i] = '0;
			expFlags[i] = '0;
			chkOp[i] = 0;
			chkDst[i] = 0;
		end
	endtask

	task automatic put(input int addr, input word_t ins, input int k, input aluOp_t op,
		input regIdx_t d, input logic [7:0] fl, input bit cOp, input bit cDst);
		imem[addr >> 2] = ins;
		kind[addr >> 2] = k;
		expOp[addr >> 2] = op;
		expDst[addr >> 2] = d;
		expFlags[addr >> 2] = fl;   // rw mr mw sh imm s1 s2 br
		chkOp[addr >> 2] = cOp;
		chkDst[addr >> 2] = cDst;
		progLen++;
	endtask

	task automatic putAlu(input int addr, input opcode_t opc, input logic [5:0] funct,
		input aluOp_t op);
		regIdx_t rd;
		rd = 5'(addr >> 2);
		put(addr, {opc, 5'd1, 5'd2, rd, 5'd0, funct}, K_PLAIN, op, rd, 8'b10000110, 1, 1);
	endtask

	task automatic putImm(input int addr, input opcode_t opc, input aluOp_t op);
		regIdx_t rt;
		rt = 5'((addr >> 2) + 3);
		put(addr, {opc, 5'd4, rt, 16'(addr ^ 'h1234)}, K_PLAIN, op, rt, 8'b10001100, 1, 1);
	endtask

	task automatic putMem(input int addr, input opcode_t opc, input logic [7:0] fl,
		input bit isLoad);
		regIdx_t rt;
		rt = 5'((addr >> 2) + 7);
		put(addr, {opc, 5'd5, rt, 16'(addr)}, K_PLAIN, '0, rt, fl, 0, isLoad);
	endtask

	task automatic putCtl(input int addr, input opcode_t opc, input int k, input int tgt);
		put(addr, {opc, 26'(tgt >> 2)}, k, '0, '0, 8'h00, 0, 0);
		jumpTo[addr >> 2] = tgt;
	endtask

	task automatic putBranch(input int addr, input opcode_t opc);
		put(addr, {opc, 5'd1, 5'd2, 16'h0010}, K_PLAIN, '0, '0, 8'b00000111, 0, 0);
	endtask

	task automatic buildTrace(input int w, input word_t pc0);
		word_t pc;
		word_t retStack [$];
		bit done;
		int n;
		pc = pc0;
		done = 0;
		n = 0;
		while (!done && n < 256) begin
			expTrace[w].push_back(pc);
			case (kind[pc[9:2]])
				K_JUMP: pc = word_t'(jumpTo[pc[9:2]]);
				K_CALL: begin
					retStack.push_back(pc + 4);
					pc = word_t'(jumpTo[pc[9:2]]);
				end
				K_RET: begin
					if (retStack.size() > 0)
						pc = retStack.pop_back();
					else
						done = 1;
				end
				K_EXIT: done = 1;
				default: pc = pc + 4;
			endcase
			n++;
		end
	endtask

	task automatic checkIssue(input int w);
		word_t pc;
		assert (iIdx[w] < expTrace[w].size()) else begin
			errors++;
			$display("Warp %0d issued more instructions than its program holds", w);
		end
		if (iIdx[w] < expTrace[w].size()) begin
			pc = expTrace[w][iIdx[w]];
			checkHex("issuePc", issuePc, pc);
			checkHex("issueInstr", issueInstr, imem[pc[9:2]]);
			if (chkOp[pc[9:2]])
				checkHex("issueAluOp", issueAluOp, expOp[pc[9:2]]);
			if (chkDst[pc[9:2]])
				checkHex("issueDst", issueDst, expDst[pc[9:2]]);
			checkHex("issueFlags", {issueRegWrite, issueMemRead, issueMemWrite, issueShared,
				issueImmValid, issueSrc1Valid, issueSrc2Valid, issueBranch}, expFlags[pc[9:2]]);
		end
	endtask

	// Launch, follow every fetch and issue cycle by cycle, then check completion timing
	task automatic runKernel(input warpMask_t mask, input word_t pc0, input bit randomAck);
		warpMask_t activeM, slotM, slotOld, elig;
		int last, pick, lowest, cyc, lastExit, doneAt, fallAt, launched;
		bit drained, ack;
		word_t pc;
		launched = 0;
		for (int w = 0; w < `WARPS; w++) begin
			expTrace[w].delete();
			fIdx[w] = 0;
			iIdx[w] = 0;
			if (mask[w]) begin
				buildTrace(w, pc0);
				launched++;
			end
		end
		startPc = pc0;
		launchMask = mask;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		activeM = mask;
		slotM = '0;
		last = `WARPS - 1;
		cyc = 0;
		lastExit = -1;
		doneAt = -1;
		fallAt = -1;
		drained = 0;
		while (!(drained && fallAt >= 0)) begin
			slotOld = slotM;
			elig = activeM & ~slotOld;
			pick = rrPick(elig, last);
			lowest = lowestSet(slotOld);
			ack = 1;
			if (randomAck) begin
				lfsr = lfsrStep(lfsr);
				ack = lfsr[0];
			end
			checkHex("issueValid", issueValid, lowest >= 0);
			if (lowest >= 0) begin
				checkHex("issueWarp", issueWarp, 1 << lowest);
				if (ack) begin
					checkIssue(lowest);
					iIdx[lowest]++;
					slotM[lowest] = 0;
				end
			end
			issueAck = ack;
			checkHex("fetchValid", fetchValid, pick >= 0);
			if (pick >= 0) begin
				checkHex("fetchWarp", fetchWarp, 1 << pick);
				assert (fIdx[pick] < expTrace[pick].size()) else begin
					errors++;
					$display("Warp %0d fetched past the end of its program", pick);
				end
				if (fIdx[pick] < expTrace[pick].size()) begin
					pc = expTrace[pick][fIdx[pick]];
					checkHex("fetchAddr", fetchAddr, pc);
					if (kind[pc[9:2]] == K_EXIT) begin
						activeM[pick] = 0;
						lastExit = cyc;
					end
				end
				fIdx[pick]++;
				slotM[pick] = 1;
				last = pick;
			end
			if (kernelDone && doneAt < 0)
				doneAt = cyc;
			if (!busy && doneAt >= 0 && fallAt < 0)
				fallAt = cyc;
			drained = 1;
			for (int w = 0; w < `WARPS; w++) begin
				if (iIdx[w] != expTrace[w].size())
					drained = 0;
			end
			cyc++;
			@(negedge clk);
		end
		issueAck = 1'b0;
		checkHex("retiredWarps", retiredWarps, launched);
		checkHex("kernelDone", kernelDone, 1);
		checkHex("kernelDone rise cycle", doneAt, lastExit + 1);
		checkHex("busy fall cycle", fallAt, lastExit + 2);
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testsRun++;
		if (errors != errBefore)
			testsFailed++;
		$display("%s: %s (%0d errors)", name, (errors == errBefore) ? "ok" : "FAILED",
			errors - errBefore);
	endtask

	task automatic testReset();
		int e;
		e = errors;
		checkHex("fetchValid", fetchValid, 0);
		checkHex("issueValid", issueValid, 0);
		checkHex("busy", busy, 0);
		checkHex("kernelDone", kernelDone, 0);
		checkHex("state", i_simtFrontEnd.i_warpScheduler.state, sIdle);
		reportTest("resetState", e);
	endtask

	task automatic testAluDecode();
		int e;
		e = errors;
		clearProgram();
		putAlu('h40, 6'b000000, 6'b100000, 4'd0);   // ADD
		putAlu('h44, 6'b000000, 6'b100010, 4'd1);
		putAlu('h48, 6'b000000, 6'b011000, 4'd2);
		putAlu('h4c, 6'b000000, 6'b100100, 4'd3);
		putAlu('h50, 6'b000000, 6'b100101, 4'd4);
		putAlu('h54, 6'b000000, 6'b100110, 4'd5);
		putAlu('h58, 6'b000000, 6'b000010, 4'd6);
		putAlu('h5c, 6'b000000, 6'b000000, 4'd7);   // SHL
		putAlu('h60, 6'b010000, 6'b100010, 4'd1);   // SUB.S
		putImm('h64, 6'b001000, 4'd0);
		putImm('h68, 6'b001100, 4'd3);
		putImm('h6c, 6'b001101, 4'd4);
		putImm('h70, 6'b011110, 4'd5);   // XORI.S
		putAlu('h74, 6'b000000, 6'b111111, 4'd15);   // Unknown funct
		putCtl('h78, 6'b100001, K_EXIT, 0);
		runKernel(8'b0000_0001, 32'h40, 0);
		reportTest("aluDecode", e);
	endtask

	task automatic testMemDecode();
		int e;
		e = errors;
		clearProgram();
		putMem('h80, 6'b100011, 8'b11001100, 1);   // LD
		putMem('h84, 6'b100111, 8'b11011100, 1);   // LDS
		putMem('h88, 6'b101011, 8'b00101110, 0);   // SW
		putMem('h8c, 6'b101111, 8'b00111110, 0);   // SWS
		putMem('h90, 6'b110011, 8'b11001100, 1);
		putMem('h94, 6'b110111, 8'b11011100, 1);
		putMem('h98, 6'b111011, 8'b00101110, 0);
		putMem('h9c, 6'b111111, 8'b00111110, 0);
		putCtl('ha0, 6'b100001, K_EXIT, 0);
		runKernel(8'b0000_0010, 32'h80, 0);
		reportTest("memDecode", e);
	endtask

	task automatic testControlFlow();
		int e;
		e = errors;
		clearProgram();
		putAlu('h200, 6'b000000, 6'b100000, 4'd0);
		putCtl('h204, 6'b000011, K_CALL, 'h300);
		putBranch('h208, 6'b000100);   // BEQ falls through
		putBranch('h20c, 6'b000111);
		putCtl('h210, 6'b000010, K_JUMP, 'h218);
		putAlu('h214, 6'b000000, 6'b100010, 4'd1);   // Skipped by the jump
		putCtl('h218, 6'b010010, K_JUMP, 'h220);
		putCtl('h220, 6'b100001, K_EXIT, 0);
		putAlu('h300, 6'b000000, 6'b100100, 4'd3);
		putCtl('h304, 6'b000011, K_CALL, 'h340);   // Nested call
		putCtl('h308, 6'b000110, K_RET, 0);
		putAlu('h340, 6'b000000, 6'b100101, 4'd4);
		putCtl('h344, 6'b000110, K_RET, 0);
		runKernel(8'b0010_0000, 32'h200, 0);
		reportTest("controlFlow", e);
	endtask

	task automatic testMultiWarp();
		int e;
		e = errors;
		clearProgram();
		putAlu('h100, 6'b000000, 6'b100000, 4'd0);
		putMem('h104, 6'b100011, 8'b11001100, 1);
		putCtl('h108, 6'b000011, K_CALL, 'h180);
		putMem('h10c, 6'b101011, 8'b00101110, 0);
		putBranch('h110, 6'b000100);
		putImm('h114, 6'b001110, 4'd5);
		putCtl('h118, 6'b100001, K_EXIT, 0);
		putAlu('h180, 6'b000000, 6'b100010, 4'd1);
		putImm('h184, 6'b001101, 4'd4);
		putCtl('h188, 6'b000110, K_RET, 0);
		runKernel(8'b1011_0010, 32'h100, 1);
		reportTest("multiWarp", e);
	endtask

	task automatic testCompletion();
		int e;
		e = errors;
		clearProgram();
		putImm('h10, 6'b001000, 4'd0);
		putAlu('h14, 6'b000000, 6'b100110, 4'd5);
		putCtl('h18, 6'b100001, K_EXIT, 0);
		runKernel(8'b1111_1111, 32'h10, 1);
		runKernel(8'b0000_0110, 32'h10, 0);   // Relaunch from sDone
		reportTest("completion", e);
	endtask

	initial begin
		start = 1'b0;
		launchMask = '0;
		startPc = '0;
		issueAck = 1'b0;
		clearProgram();
		@(negedge clk);
		while (rst)
			@(negedge clk);
		testReset();
		testAluDecode();
		testMemDecode();
		testControlFlow();
		testMultiWarp();
		testCompletion();
		errors += i_simtFrontEnd.i_checker.failCount;   // Bound assertion failures
		$display("Tests run: %0d, tests failed: %0d, errors: %0d", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+src
src/simtPkg.sv
src/instrDecode.sv
src/warpScheduler.sv
src/pcTable.sv
src/callStack.sv
src/instrBuffer.sv
src/retireCounter.sv
src/simtFrontEnd.sv
bench/clockGen.sv
bench/simtFrontEnd_checker.sv
bench/simtFrontEnd_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = simtFrontEnd_tb
FILELIST = compile.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJDIR)
